/* logic/matrix_pkg.sv */
package matrix_pkg;

	// ==================================================
	// matrix limits
	// ==================================================
	localparam int MAX_DIM   = 5;                  // rows and cols top out here
	localparam int MAX_ELEMS = MAX_DIM * MAX_DIM;  // 25 element slots

	typedef logic [7:0] elem_t;  // one byte, digits 0 to 9 in a matrix
	typedef logic [2:0] dim_t;   // row or col count

	// row-major, element 0 in elems[0]
	typedef struct packed {
		dim_t                        rows;
		dim_t                        cols;
		elem_t [MAX_ELEMS-1:0]       elems;
	} matrix_t;

	// store to printer, valid is a single-cycle strobe
	typedef struct packed {
		matrix_t mat;
		logic    valid;
	} print_job_t;

	// ==================================================
	// ascii codes
	// ==================================================
	localparam elem_t CHAR_SPACE = 8'h20;
	localparam elem_t CHAR_CR    = 8'h0d;
	localparam elem_t CHAR_LF    = 8'h0a;
	localparam elem_t CHAR_ZERO  = 8'h30;  // '0'
	localparam elem_t CHAR_PRINT = 8'h70;  // 'p' starts a print command

endpackage

/* logic/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx
	import matrix_pkg::*;
#(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  uart_rxd,
	output elem_t rx_data,
	output logic  rx_valid
);

	localparam int               CNT_W    = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t        state;
	logic [1:0]       sync_q;   // two-flop synchroniser
	logic             rxd_s;
	logic [CNT_W-1:0] clk_cnt;  // cycles within the current bit
	logic [2:0]       bit_idx;
	elem_t            shift_q;

	assign rxd_s   = sync_q[1];
	assign rx_data = shift_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q   <= 2'b11;  // line idles high
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			sync_q   <= {sync_q[0], uart_rxd};
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (!rxd_s)
						state <= RX_START;  // falling edge, maybe a start bit
				end
				RX_START: begin
					if (clk_cnt == HALF_BIT) begin
						clk_cnt <= '0;
						state   <= rxd_s ? RX_IDLE : RX_DATA;  // glitch goes back to idle
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (clk_cnt == FULL_BIT) begin
						clk_cnt <= '0;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (clk_cnt == FULL_BIT) begin
						state    <= RX_IDLE;
						rx_valid <= rxd_s;  // low stop bit drops the frame
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb first, sampled at bit centre
	always_ff @(posedge clk) begin
		if (state == RX_DATA && clk_cnt == FULL_BIT)
			shift_q <= {rxd_s, shift_q[7:1]};
	end

	// parser relies on one byte per strobe
	a_rx_valid_single : assert property (@(posedge clk) disable iff (!rst_n)
		rx_valid |=> !rx_valid);

endmodule

/* logic/matrix_parser.sv */
`timescale 1ns/1ps

module matrix_parser
	import matrix_pkg::*;
#(
	parameter int NUM_SLOTS = 2
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  elem_t                        rx_data,
	input  logic                         rx_valid,
	output logic                         store_req,
	output matrix_t                      matrix,
	output logic                         print_req,
	output logic [$clog2(NUM_SLOTS)-1:0] print_slot,
	output logic                         parse_error
);

	localparam int SLOT_W = $clog2(NUM_SLOTS);

	typedef enum logic [1:0] {P_IDLE, P_COLS, P_ELEMS, P_SLOT} parse_state_t;

	parse_state_t state;
	logic [4:0]   elem_cnt;    // next element to fill
	logic [4:0]   elem_total;  // rows * cols, at most 25
	logic         is_sep;
	logic         is_digit;
	logic         dim_ok;
	logic         slot_ok;
	elem_t        digit;

	// ==================================================
	// character classes
	// ==================================================
	assign is_sep     = rx_data inside {CHAR_SPACE, CHAR_CR, CHAR_LF};
	assign is_digit   = (rx_data >= CHAR_ZERO) && (rx_data <= CHAR_ZERO + 8'd9);
	assign digit      = rx_data - CHAR_ZERO;
	assign dim_ok     = is_digit && (digit >= 8'd1) && (digit <= 8'(MAX_DIM));
	assign slot_ok    = is_digit && (digit < 8'(NUM_SLOTS));
	assign elem_total = {2'b00, matrix.rows} * {2'b00, matrix.cols};

	// ==================================================
	// control fsm
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= P_IDLE;
			elem_cnt    <= '0;
			store_req   <= 1'b0;
			print_req   <= 1'b0;
			parse_error <= 1'b0;
		end else begin
			store_req   <= 1'b0;
			print_req   <= 1'b0;
			parse_error <= 1'b0;
			if (rx_valid && !is_sep) begin  // separators never change state
				case (state)
					P_IDLE: begin
						if (rx_data == CHAR_PRINT)
							state <= P_SLOT;
						else if (dim_ok)
							state <= P_COLS;  // rows digit taken
						else
							parse_error <= 1'b1;
					end
					P_COLS: begin
						elem_cnt <= '0;
						if (dim_ok) begin
							state <= P_ELEMS;
						end else begin
							parse_error <= 1'b1;
							state       <= P_IDLE;
						end
					end
					P_ELEMS: begin
						if (!is_digit) begin
							parse_error <= 1'b1;
							state       <= P_IDLE;
						end else if (elem_cnt == elem_total - 5'd1) begin
							store_req <= 1'b1;  // last element in
							state     <= P_IDLE;
						end else begin
							elem_cnt <= elem_cnt + 1'b1;
						end
					end
					P_SLOT: begin
						if (slot_ok)
							print_req <= 1'b1;
						else
							parse_error <= 1'b1;
						state <= P_IDLE;
					end
					default: state <= P_IDLE;
				endcase
			end
		end
	end

	// record fields, only sampled by the store on its strobes
	always_ff @(posedge clk) begin
		if (rx_valid && !is_sep) begin
			case (state)
				P_IDLE:  matrix.rows <= digit[2:0];
				P_COLS: begin
					matrix.cols  <= digit[2:0];
					matrix.elems <= '0;  // unused tail reads as zero
				end
				P_ELEMS: matrix.elems[elem_cnt] <= digit;
				P_SLOT:  print_slot <= digit[SLOT_W-1:0];
				default: ;
			endcase
		end
	end

endmodule

/* logic/matrix_store.sv */
`timescale 1ns/1ps

module matrix_store
	import matrix_pkg::*;
#(
	parameter int NUM_SLOTS = 2
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           store_req,
	input  matrix_t                        matrix,
	input  logic                           print_req,
	input  logic [$clog2(NUM_SLOTS)-1:0]   print_slot,
	output print_job_t                     job,
	output logic                           slot_empty_error,
	output logic [$clog2(NUM_SLOTS+1)-1:0] stored_count
);

	localparam int SLOT_W  = $clog2(NUM_SLOTS);
	localparam int COUNT_W = $clog2(NUM_SLOTS + 1);

	matrix_t              slots [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] filled;   // per slot, set on first write
	logic [SLOT_W-1:0]    wr_ptr;   // oldest slot in ring order
	matrix_t              job_mat;
	logic                 job_valid;

	assign job.mat   = job_mat;
	assign job.valid = job_valid;

	// ==================================================
	// ring pointer, flags and job strobe
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			filled           <= '0;
			wr_ptr           <= '0;
			stored_count     <= '0;
			job_valid        <= 1'b0;
			slot_empty_error <= 1'b0;
		end else begin
			job_valid        <= 1'b0;
			slot_empty_error <= 1'b0;
			if (store_req) begin
				filled[wr_ptr] <= 1'b1;
				wr_ptr         <= (wr_ptr == SLOT_W'(NUM_SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
				if (stored_count != COUNT_W'(NUM_SLOTS))
					stored_count <= stored_count + 1'b1;  // saturates when full
				job_valid <= 1'b1;  // echo what was just written
			end else if (print_req) begin
				job_valid        <= filled[print_slot];
				slot_empty_error <= !filled[print_slot];  // no job for an empty slot
			end
		end
	end

	// slot contents and job payload
	always_ff @(posedge clk) begin
		if (store_req) begin
			slots[wr_ptr] <= matrix;
			job_mat       <= matrix;
		end else if (print_req) begin
			job_mat <= slots[print_slot];
		end
	end

	// parser issues at most one request per byte
	a_req_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
		!(store_req && print_req));

endmodule

/* logic/matrix_printer.sv */
`timescale 1ns/1ps

module matrix_printer
	import matrix_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  print_job_t job,
	input  logic       tx_busy,
	output logic       tx_start,
	output elem_t      tx_data
);

	typedef enum logic [2:0] {PR_IDLE, PR_DIGIT, PR_SPACE, PR_CR, PR_LF} pr_state_t;

	pr_state_t  state;
	matrix_t    mat_q;     // latched job
	dim_t       row;
	dim_t       col;
	logic [4:0] idx;       // row-major element index
	logic       tx_ready;
	elem_t      next_char;

	// busy rises a cycle after tx_start, so hold off that cycle too
	assign tx_ready = !tx_busy && !tx_start;

	always_comb begin
		case (state)
			PR_DIGIT: next_char = CHAR_ZERO + mat_q.elems[idx];
			PR_CR:    next_char = CHAR_CR;
			PR_LF:    next_char = CHAR_LF;
			default:  next_char = CHAR_SPACE;
		endcase
	end

	// ==================================================
	// character sequencer
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= PR_IDLE;
			row      <= '0;
			col      <= '0;
			idx      <= '0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (state == PR_IDLE) begin
				if (job.valid) begin  // jobs arriving while busy are dropped
					state <= PR_DIGIT;
					row   <= '0;
					col   <= '0;
					idx   <= '0;
				end
			end else if (tx_ready) begin
				tx_start <= 1'b1;
				case (state)
					PR_DIGIT: state <= (col == mat_q.cols - 3'd1) ? PR_CR : PR_SPACE;
					PR_SPACE: begin
						col   <= col + 1'b1;
						idx   <= idx + 1'b1;
						state <= PR_DIGIT;
					end
					PR_CR: state <= PR_LF;
					PR_LF: begin
						if (row == mat_q.rows - 3'd1) begin
							state <= PR_IDLE;  // last lf handed over
						end else begin
							row   <= row + 1'b1;
							col   <= '0;
							idx   <= idx + 1'b1;
							state <= PR_DIGIT;
						end
					end
					default: state <= PR_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == PR_IDLE && job.valid)
			mat_q <= job.mat;
		if (state != PR_IDLE && tx_ready)
			tx_data <= next_char;  // goes out with tx_start
	end

	// handshake with uart_tx busy flag
	a_start_when_idle : assert property (@(posedge clk) disable iff (!rst_n)
		$rose(tx_start) |-> !tx_busy);

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
	import matrix_pkg::*;
#(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  tx_start,
	input  elem_t tx_data,
	output logic  uart_txd,
	output logic  tx_busy
);

	localparam int               CNT_W    = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;  // 0 start, 1..8 data, 9 stop
	logic [8:0]       shift_q;  // stop bit above the data byte

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uart_txd <= 1'b1;
			tx_busy  <= 1'b0;
			clk_cnt  <= '0;
			bit_idx  <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_busy  <= 1'b1;
				uart_txd <= 1'b0;  // start bit
				clk_cnt  <= '0;
				bit_idx  <= '0;
			end
		end else if (clk_cnt != FULL_BIT) begin
			clk_cnt <= clk_cnt + 1'b1;
		end else begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9) begin
				tx_busy  <= 1'b0;  // stop bit done
				uart_txd <= 1'b1;
			end else begin
				uart_txd <= shift_q[0];
				bit_idx  <= bit_idx + 1'b1;
			end
		end
	end

	// lsb first, ones shifted in behind
	always_ff @(posedge clk) begin
		if (!tx_busy && tx_start)
			shift_q <= {1'b1, tx_data};
		else if (tx_busy && clk_cnt == FULL_BIT)
			shift_q <= {1'b1, shift_q[8:1]};
	end

endmodule

/* logic/matrix_echo_top.sv */
`timescale 1ns/1ps

module matrix_echo_top
	import matrix_pkg::*;
#(
	parameter int CLKS_PER_BIT = 8,
	parameter int NUM_SLOTS    = 2
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           uart_rxd,
	output logic                           uart_txd,
	output logic                           parse_error,
	output logic [$clog2(NUM_SLOTS+1)-1:0] stored_count
);

	elem_t                        rx_data;
	logic                         rx_valid;
	logic                         store_req;
	matrix_t                      parsed_matrix;
	logic                         print_req;
	logic [$clog2(NUM_SLOTS)-1:0] print_slot;
	logic                         syntax_error;      // from the parser
	logic                         slot_empty_error;  // from the store
	print_job_t                   job;
	logic                         tx_start;
	elem_t                        tx_data;
	logic                         tx_busy;

	// both sources are single-cycle strobes
	assign parse_error = syntax_error | slot_empty_error;

	// ==================================================
	// input side
	// ==================================================
	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
		.clk      (clk),
		.rst_n    (rst_n),
		.uart_rxd (uart_rxd),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	matrix_parser #(.NUM_SLOTS(NUM_SLOTS)) u_parser (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_data     (rx_data),
		.rx_valid    (rx_valid),
		.store_req   (store_req),
		.matrix      (parsed_matrix),
		.print_req   (print_req),
		.print_slot  (print_slot),
		.parse_error (syntax_error)
	);

	// storage ring, echoes every write
	matrix_store #(.NUM_SLOTS(NUM_SLOTS)) u_store (
		.clk              (clk),
		.rst_n            (rst_n),
		.store_req        (store_req),
		.matrix           (parsed_matrix),
		.print_req        (print_req),
		.print_slot       (print_slot),
		.job              (job),
		.slot_empty_error (slot_empty_error),
		.stored_count     (stored_count)
	);

	// ==================================================
	// output side
	// ==================================================
	matrix_printer u_printer (
		.clk      (clk),
		.rst_n    (rst_n),
		.job      (job),
		.tx_busy  (tx_busy),
		.tx_start (tx_start),
		.tx_data  (tx_data)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.uart_txd (uart_txd),
		.tx_busy  (tx_busy)  // only back-pressure in the path
	);

endmodule

/* bench/matrix_echo_tb_tasks.svh */
`ifndef MATRIX_ECHO_TB_TASKS_SVH
`define MATRIX_ECHO_TB_TASKS_SVH

// galois form, x^32 + x^30 + x^26 + x^25 + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0);
endfunction

// four bits per draw, one step each, values above 9 redrawn
task automatic rand_digit(output logic [3:0] d);
	int i;
	do begin
		for (i = 0; i < 4; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			d = {d[2:0], lfsr_state[0]};
		end
	end while (d > 4'd9);
endtask

task automatic fill_random(input int k, input int rows, input int cols);
	int i;
	saved_rows[k] = rows;
	saved_cols[k] = cols;
	for (i = 0; i < rows * cols; i++)
		rand_digit(saved_el[k][i]);
endtask

// 8N1 frame, called on a rising edge
task automatic send_byte(input logic [7:0] b);
	logic [9:0] frame;
	int         i;
	frame = {1'b1, b, 1'b0};  // stop, data, start
	for (i = 0; i < 10; i++) begin
		uart_rxd <= frame[i];
		repeat (CLKS_PER_BIT) @(posedge clk);
	end
endtask

task automatic send_text(input string s);
	int i;
	for (i = 0; i < s.len(); i++)
		send_byte(s[i]);
endtask

// seps adds spaces and cr lf between the characters
task automatic send_matrix(input int k, input logic seps);
	int r;
	int c;
	send_byte(CHAR_ZERO + 8'(saved_rows[k]));
	if (seps)
		send_text("  ");
	send_byte(CHAR_ZERO + 8'(saved_cols[k]));
	if (seps)
		send_text("\r\n");
	for (r = 0; r < saved_rows[k]; r++)
		for (c = 0; c < saved_cols[k]; c++) begin
			send_byte(CHAR_ZERO + {4'h0, saved_el[k][r * saved_cols[k] + c]});
			if (seps && c == saved_cols[k] - 1)
				send_text("\r\n");
			else if (seps)
				send_byte(CHAR_SPACE);
		end
endtask

// digits split by single spaces, cr lf per row
task automatic expect_matrix(input int k);
	int r;
	int c;
	for (r = 0; r < saved_rows[k]; r++) begin
		for (c = 0; c < saved_cols[k]; c++) begin
			exp_bytes.push_back(CHAR_ZERO + {4'h0, saved_el[k][r * saved_cols[k] + c]});
			if (c < saved_cols[k] - 1)
				exp_bytes.push_back(CHAR_SPACE);
		end
		exp_bytes.push_back(CHAR_CR);
		exp_bytes.push_back(CHAR_LF);
	end
endtask

`endif

/* bench/matrix_echo_tb.sv */
`timescale 1ns/1ps

module matrix_echo_tb
	import matrix_pkg::*;
();

	localparam int CLKS_PER_BIT = 8;
	localparam int NUM_SLOTS    = 2;
	localparam int BYTE_CYCLES  = 10 * CLKS_PER_BIT;  // one 8N1 frame
	// ~110 bytes sent, ~120 echoed, ~20 frames of idle checks, doubled
	localparam int MAX_CYCLES   = 2 * 260 * BYTE_CYCLES;

	logic        clk;
	logic        rst_n;
	logic        uart_rxd;
	logic        uart_txd;
	logic        parse_error;
	logic [1:0]  stored_count;

	logic [7:0]  rx_bytes[$];   // decoded from uart_txd
	logic [7:0]  exp_bytes[$];  // built from the print format rules
	logic [31:0] lfsr_state;
	logic        quiet;         // uart_txd must stay idle while set
	int          err_pulses;    // parse_error strobes seen
	int          pulses_seen;   // strobes accounted for so far
	int          error_count;
	int          err_at_start;
	int          tests_run;
	int          tests_failed;
	int          cycle_count;

	// bench copies of sent matrices, row-major
	logic [3:0]  saved_el[3][MAX_ELEMS];
	int          saved_rows[3];
	int          saved_cols[3];

	matrix_echo_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .NUM_SLOTS(NUM_SLOTS)) UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.uart_rxd     (uart_rxd),
		.uart_txd     (uart_txd),
		.parse_error  (parse_error),
		.stored_count (stored_count)
	);

	`include "matrix_echo_tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	// ==================================================
	// watchdog and monitors
	// ==================================================
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	always @(posedge clk)
		if (rst_n && parse_error)
			err_pulses <= err_pulses + 1;

	// bench uart receiver, samples at bit centres
	initial begin : tx_monitor
		logic [7:0] b;
		int         i;
		forever begin
			@(posedge clk);
			if (rst_n && uart_txd === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(posedge clk);  // middle of start bit
				for (i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(posedge clk);
					b[i] = uart_txd;  // lsb first
				end
				repeat (CLKS_PER_BIT) @(posedge clk);
				assert (uart_txd === 1'b1) else begin
					$display("stop bit on uart_txd was not high");
					error_count++;
				end
				rx_bytes.push_back(b);
			end
		end
	end

	a_err_strobe : assert property (@(posedge clk) disable iff (!rst_n)
		parse_error |=> !parse_error)
		else begin
			$display("parse_error stayed high for more than one cycle");
			error_count++;
		end

	a_quiet_line : assert property (@(posedge clk) disable iff (!rst_n)
		quiet |-> uart_txd)
		else begin
			$display("uart_txd left idle where no output was allowed");
			error_count++;
		end

	a_count_range : assert property (@(posedge clk) disable iff (!rst_n)
		stored_count <= 2'(NUM_SLOTS))
		else begin
			$display("ERROR stored_count = 0x%0h, above 0x%0h", stored_count, NUM_SLOTS);
			error_count++;
		end

	// ==================================================
	// checks and test bookkeeping
	// ==================================================
	task automatic check_output();
		int i;
		while (rx_bytes.size() < exp_bytes.size())
			@(posedge clk);
		repeat (2 * BYTE_CYCLES) @(posedge clk);  // room for stray bytes
		assert (rx_bytes.size() == exp_bytes.size()) else begin
			$display("ERROR uart_txd byte count = 0x%0h, expected 0x%0h",
				rx_bytes.size(), exp_bytes.size());
			error_count++;
		end
		for (i = 0; i < exp_bytes.size() && i < rx_bytes.size(); i++)
			assert (rx_bytes[i] === exp_bytes[i]) else begin
				$display("ERROR uart_txd byte %0d = 0x%02h, expected 0x%02h",
					i, rx_bytes[i], exp_bytes[i]);
				error_count++;
			end
		rx_bytes.delete();
		exp_bytes.delete();
	endtask

	task automatic expect_error();
		repeat (3) @(posedge clk);  // strobe one cycle later via the store, then counted
		assert (err_pulses == pulses_seen + 1) else begin
			$display("ERROR parse_error pulses = 0x%0h, expected 0x%0h",
				err_pulses, pulses_seen + 1);
			error_count++;
		end
		pulses_seen = err_pulses;
	endtask

	task automatic check_count(input int n);
		assert (stored_count === 2'(n)) else begin
			$display("ERROR stored_count = 0x%0h, expected 0x%0h", stored_count, n);
			error_count++;
		end
	endtask

	task automatic start_test();
		err_at_start = error_count;
		pulses_seen  = err_pulses;
	endtask

	task automatic end_test(input string name);
		assert (err_pulses == pulses_seen) else begin
			$display("ERROR parse_error pulses = 0x%0h, expected 0x%0h",
				err_pulses, pulses_seen);
			error_count++;
		end
		tests_run++;
		if (error_count == err_at_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED", tests_run, name);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		rx_bytes.delete();
		exp_bytes.delete();
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		rst_n      = 1'b0;
		uart_rxd   = 1'b1;  // line idles high
		quiet      = 1'b0;
		lfsr_state = 32'h014c_33db;
		apply_reset();

		start_test();
		fill_random(0, 2, 3);
		send_matrix(0, 1'b0);
		expect_matrix(0);
		check_output();
		check_count(1);
		end_test("echo on store");

		start_test();
		fill_random(1, 5, 5);
		send_matrix(1, 1'b1);  // padded with spaces and line ends
		expect_matrix(1);
		check_output();
		fill_random(2, 1, 1);
		send_matrix(2, 1'b1);
		expect_matrix(2);
		check_output();
		check_count(2);  // saturated
		end_test("separators and limits");

		start_test();
		apply_reset();
		fill_random(0, 2, 2);
		send_matrix(0, 1'b0);
		expect_matrix(0);
		check_output();
		fill_random(1, 1, 3);
		send_matrix(1, 1'b0);
		expect_matrix(1);
		check_output();
		fill_random(2, 3, 1);
		send_matrix(2, 1'b0);  // overwrites slot 0
		expect_matrix(2);
		check_output();
		send_text("p0");
		expect_matrix(2);
		check_output();
		send_text("p1");
		expect_matrix(1);
		check_output();
		end_test("ring order and print by slot");

		start_test();
		quiet <= 1'b1;
		send_text("0");     // rows 0
		expect_error();
		send_text("26");    // cols 6
		expect_error();
		send_text("123a");  // bad element
		expect_error();
		send_text("p7");    // slot out of range
		expect_error();
		check_output();
		check_count(2);
		quiet <= 1'b0;
		end_test("range errors");

		start_test();
		apply_reset();
		quiet <= 1'b1;
		send_text("p0");
		expect_error();
		check_count(0);
		check_output();
		quiet <= 1'b0;
		end_test("empty slot");

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+bench
logic/matrix_pkg.sv
logic/uart_rx.sv
logic/matrix_parser.sv
logic/matrix_store.sv
logic/matrix_printer.sv
logic/uart_tx.sv
logic/matrix_echo_top.sv
bench/matrix_echo_tb.sv

/* Bender.yml */
package:
  name: matrix_echo

sources:
  - logic/matrix_pkg.sv
  - logic/uart_rx.sv
  - logic/matrix_parser.sv
  - logic/matrix_store.sv
  - logic/matrix_printer.sv
  - logic/uart_tx.sv
  - logic/matrix_echo_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/matrix_echo_tb.sv
